// File: dv/obj_clock_gen.sv
// Testbench clock and reset source
// 8 ns clock, synchronous reset held low for 10 rising edges
`timescale 1ns/1ps

module obj_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release lands just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: dv/obj_line_render_assertions.sv
// Protocol checks for the sprite line renderer
// Drawer burst length and the read to pixel latency
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_line_render_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 busy,
    input logic                 rd,
    input logic [`OBJ_AW-1:0]   rd_addr,
    input logic                 pix_valid,
    input logic [`OBJ_AW-1:0]   pix_h
);

    // A burst is exactly one row of pixels, preceded by an idle cycle
    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> ($past(busy, `OBJ_ROW_PIX) && !$past(busy, `OBJ_ROW_PIX + 1)))
        else $error("busy burst length differs from one sprite row");

    // Pixel leaves three cycles after its read
    a_pix_lat: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid == $past(rd, `OBJ_BLANK_DLY + 1))
        else $error("pix_valid does not follow rd by three cycles");

    a_pix_h: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> (pix_h == $past(rd_addr, `OBJ_BLANK_DLY + 1)))
        else $error("pix_h does not match the delayed read address");

endmodule

bind obj_line_render obj_line_render_assertions i_obj_line_render_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .rd        (rd),
    .rd_addr   (rd_addr),
    .pix_valid (pix_valid),
    .pix_h     (pix_h)
);

// File: dv/obj_line_render_input.txt
# D x pal row draws a sprite row, all fields hex, pixel 0 in the low row nibble
# F v sets flip for later draws, L ends the current line
L
D 010 3 76543210
D 0f8 5 01234567
L
L
D 020 2 11111111
D 024 6 f2f2f2f2
L
D 040 1 abcdef01
L
L
L
F 1
D 000 7 89abcdef
D 0f0 4 12345678
D 100 9 12345678
F 0
D 080 b 1234567f
L
L
L

// File: dv/obj_line_render_tb.sv
// Sprite line renderer testbench
// Replays draw, flip and line commands from the input file and checks
// every output pixel against a two-bank model of the line buffer
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_line_render_tb;

    import obj_pkg::*;

    localparam int TMO   = 2000;
    localparam int LINE  = `OBJ_LINE_LEN;
    localparam int DEPTH = 1 << `OBJ_AW;

    logic               clk;
    logic               rst_n;
    logic               lhbl;
    logic               flip;
    logic               draw;
    obj_draw_t          draw_req;
    logic               busy;
    logic               pix_valid;
    logic [`OBJ_AW-1:0] pix_h;
    obj_pix_t           pix;

    // Model banks, indexed like the DUT bank bit
    logic [`OBJ_DW-1:0] model_mem [2][DEPTH];
    logic               mline;
    // Pixels as they leave the DUT, base marks the next unchecked one
    logic [`OBJ_AW-1:0] h_q [$];
    logic [`OBJ_DW-1:0] p_q [$];
    int                 base;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 err_mark;
    bit                 aborted;

    obj_clock_gen i_obj_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    obj_line_render i_obj_line_render (
        .clk       (clk),
        .rst_n     (rst_n),
        .lhbl      (lhbl),
        .flip      (flip),
        .draw      (draw),
        .draw_req  (draw_req),
        .busy      (busy),
        .pix_valid (pix_valid),
        .pix_h     (pix_h),
        .pix       (pix)
    );

    // Falling edge sampling, clear of register updates
    always @(negedge clk) begin
        if (rst_n && pix_valid) begin
            h_q.push_back(pix_h);
            p_q.push_back(pix);
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, sig, exp, act);
    endtask

    task automatic timed_out(input string what);
        errors++;
        aborted = 1'b1;
        $display("TIMEOUT at %0t ns: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TMO) begin
            step();
            n++;
        end
        if (busy) begin
            timed_out("drawer never left busy");
        end
    endtask

    // Strobe one draw, update the model, time the busy burst
    task automatic do_draw(input logic [8:0] x, input logic [3:0] pal, input logic [31:0] row);
        int n;
        logic [`OBJ_AW-1:0] a;
        logic [3:0] c;
        wait_idle();
        if (aborted) return;
        draw_req.x   = x;
        draw_req.pal = pal;
        draw_req.row = row;
        draw = 1'b1;
        step();
        draw = 1'b0;
        for (int i = 0; i < `OBJ_ROW_PIX; i++) begin
            c = 4'(row >> (4 * i));
            a = x + 9'(i);
            // Mirror across the 256-pixel line, wrapping at 512
            if (flip) a = 9'(255 - int'(a));
            if (c != `OBJ_ALPHA) model_mem[mline][a] = {pal, c};
        end
        checks++;
        if (!busy) begin
            errors++;
            $display("ERROR at %0t ns: draw strobe was not accepted", $time);
            return;
        end
        n = 0;
        while (busy && n < TMO) begin
            n++;
            step();
        end
        if (busy) begin
            timed_out("busy burst did not end");
        end else if (n != `OBJ_ROW_PIX) begin
            mismatch("busy cycles", 32'(`OBJ_ROW_PIX), 32'(n));
        end
    endtask

    // Collect and check one line, then run the blank and swap banks
    task automatic finish_line(input bit check_pix);
        int n;
        logic [`OBJ_AW-1:0] h;
        logic [`OBJ_DW-1:0] exp;
        logic rb;
        n = 0;
        while (h_q.size() - base < LINE && n < TMO) begin
            step();
            n++;
        end
        if (h_q.size() - base < LINE) begin
            timed_out("a line of pixels did not arrive");
            return;
        end
        rb = ~mline;
        for (int k = 0; k < LINE; k++) begin
            h = h_q[base + k];
            checks++;
            if (h != 9'(k)) mismatch("pix_h", 32'(k), 32'(h));
            if (check_pix) begin
                exp = model_mem[rb][h];
                checks++;
                if (p_q[base + k] != exp) begin
                    mismatch($sformatf("pix at h=%0d", h), 32'(exp), 32'(p_q[base + k]));
                end
            end
            // Erased behind the reader
            model_mem[rb][h] = `OBJ_BLANK;
        end
        base += LINE;
        lhbl = 1'b0;
        repeat (64) step();
        checks++;
        if (h_q.size() != base) begin
            errors++;
            $display("ERROR at %0t ns: pixels came out during blank", $time);
        end
        mline = ~mline;
        lhbl = 1'b1;
    endtask

    initial begin : main
        int fd;
        int c;
        int n;
        int nline;
        logic [7:0] ch;
        logic [`OBJ_AW-1:0] x;
        logic [3:0] pal;
        logic [31:0] row;
        logic [31:0] v;
        lhbl = 1'b0;
        flip = 1'b0;
        draw = 1'b0;
        draw_req = '0;
        mline = 1'b0;
        nline = 0;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < DEPTH; a++) model_mem[1'(b)][9'(a)] = `OBJ_BLANK;
        end
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            step();
            n++;
        end
        if (rst_n !== 1'b1) timed_out("reset was never released");
        if (!aborted) begin
            step();
            checks += 2;
            if (busy != 1'b0) mismatch("busy", 32'd0, 32'(busy));
            if (pix_valid != 1'b0) mismatch("pix_valid", 32'd0, 32'(pix_valid));
            end_test("reset state");
            // RAM starts unknown, two unchecked lines leave it blank
            lhbl = 1'b1;
            finish_line(1'b0);
            if (!aborted) finish_line(1'b0);
            if (!aborted) end_test("warm-up lines");
        end
        fd = $fopen("dv/obj_line_render_input.txt", "r");
        if (fd == 0 && !aborted) begin
            errors++;
            aborted = 1'b1;
            $display("ERROR: cannot open the input file");
        end
        n = 0;
        while (!aborted && n < 100000) begin
            n++;
            c = $fgetc(fd);
            if (c < 0) break;
            ch = 8'(c);
            if (ch == "#") begin
                while (c >= 0 && c != 10) c = $fgetc(fd);
            end else if (ch == "D") begin
                if ($fscanf(fd, "%h %h %h", x, pal, row) != 3) begin
                    errors++;
                    aborted = 1'b1;
                    $display("ERROR: malformed draw command in the input file");
                end else begin
                    do_draw(x, pal, row);
                end
            end else if (ch == "F") begin
                if ($fscanf(fd, "%h", v) == 1) begin
                    // Flip must not change in the middle of a burst
                    wait_idle();
                    flip = v[0];
                end else begin
                    errors++;
                    aborted = 1'b1;
                    $display("ERROR: malformed flip command in the input file");
                end
            end else if (ch == "L") begin
                nline++;
                finish_line(1'b1);
                if (!aborted) end_test($sformatf("line %0d", nline));
            end
        end
        if (fd != 0) $fclose(fd);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: obj_line_render.f
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_dual_ram.sv
rtl/obj_row_drawer.sv
rtl/obj_scan_reader.sv
rtl/obj_line_buffer.sv
rtl/obj_line_render.sv
dv/obj_clock_gen.sv
dv/obj_line_render_assertions.sv
dv/obj_line_render_tb.sv

// File: rtl/obj_dual_ram.sv
// Dual-port line RAM
// Two read/write ports on one clock, read-before-write, registered q
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_dual_ram (
    input  logic                 clk,
    // Port 0
    input  logic [`OBJ_AW:0]     addr0,
    input  logic [`OBJ_DW-1:0]   data0,
    input  logic                 we0,
    output logic [`OBJ_DW-1:0]   q0,
    // Port 1
    input  logic [`OBJ_AW:0]     addr1,
    input  logic [`OBJ_DW-1:0]   data1,
    input  logic                 we1,
    output logic [`OBJ_DW-1:0]   q1
);

    // Two banks, so one address bit above the pixel address
    localparam int AW    = `OBJ_AW + 1;
    localparam int DEPTH = 2 ** AW;

    logic [`OBJ_DW-1:0] mem [DEPTH];

    // Both ports in one process
    // Reads sample the old contents before the write lands
    always_ff @(posedge clk) begin
        q0 <= mem[addr0];
        q1 <= mem[addr1];
        if (we0) begin
            mem[addr0] <= data0;
        end
        // Port 1 wins a same-address collision
        // Banks differ in normal use, so it never happens
        if (we1) begin
            mem[addr1] <= data1;
        end
    end

endmodule

// File: rtl/obj_line_buffer.sv
// Double-banked sprite line buffer
// Port 0 takes drawer writes with transparency and flip applied
// Port 1 reads the other bank and erases each pixel after reading
// Banks swap at the start of horizontal blank
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_line_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lhbl,
    input  logic                 flip,
    input  logic                 we,
    input  obj_pkg::obj_wr_t     wr,
    input  logic                 rd,
    input  logic [`OBJ_AW-1:0]   rd_addr,
    output logic                 pix_valid,
    output logic [`OBJ_AW-1:0]   pix_h,
    output obj_pkg::obj_pix_t    pix
);

    import obj_pkg::*;

    localparam int NSTG = `OBJ_BLANK_DLY + 1;
    // Stage that drives the port 1 read and erase
    localparam int ERS  = `OBJ_BLANK_DLY - 1;

    // Read tag, bank kept so in-flight reads survive a swap
    typedef struct packed {
        logic               bank;
        logic [`OBJ_AW-1:0] addr;
    } rd_tag_t;

    logic               line;
    logic               lhbl_q;
    logic [`OBJ_DW-1:0] wr_data;
    logic [`OBJ_AW-1:0] wr_af;
    logic               wr_ok;
    logic [`OBJ_DW-1:0] q1;
    logic [NSTG-1:0]    vld;
    rd_tag_t            tag [NSTG];

    // Bank toggles on the cycle after lhbl is seen falling
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_q <= 1'b0;
            line   <= 1'b0;
        end else begin
            lhbl_q <= lhbl;
            if (lhbl_q && !lhbl) begin
                line <= ~line;
            end
        end
    end

    // Transparent colour never reaches the RAM
    assign wr_data = wr.pix;
    assign wr_ok   = we && (wr_data[`OBJ_ALPHAW-1:0] != `OBJ_ALPHA);

    // Mirror around the visible line when flipped, wraps at 512
    assign wr_af = flip ? (~wr.addr + `OBJ_FLIP_OFFSET) : wr.addr;

    // Read valid pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[NSTG-2:0], rd};
        end
    end

    // Address and bank ride alongside the valid bits
    always_ff @(posedge clk) begin
        tag[0].bank <= ~line;
        tag[0].addr <= rd_addr;
        for (int i = 1; i < NSTG; i++) begin
            tag[i] <= tag[i-1];
        end
    end

    // Write bank on port 0, read-and-erase on port 1
    obj_dual_ram i_obj_dual_ram (
        .clk   (clk),
        .addr0 ({line, wr_af}),
        .data0 (wr_data),
        .we0   (wr_ok),
        .q0    (),
        .addr1 ({tag[ERS].bank, tag[ERS].addr}),
        .data1 (`OBJ_BLANK),
        .we1   (vld[ERS]),
        .q1    (q1)
    );

    // q1 is already registered, so output lines up with the last stage
    assign pix_valid = vld[NSTG-1];
    assign pix_h     = tag[NSTG-1].addr;
    assign pix       = obj_pix_t'(q1);

endmodule

// File: rtl/obj_line_render.sv
// Sprite line renderer top level
// Row drawer fills one bank while the scan reader empties the other
// Pixels come out three cycles after each read
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_line_render (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lhbl,
    input  logic                 flip,
    input  logic                 draw,
    input  obj_pkg::obj_draw_t   draw_req,
    output logic                 busy,
    output logic                 pix_valid,
    output logic [`OBJ_AW-1:0]   pix_h,
    output obj_pkg::obj_pix_t    pix
);

    import obj_pkg::*;

    // Drawer to buffer
    obj_wr_t            wr;
    logic               we;

    // Reader to buffer
    logic               rd;
    logic [`OBJ_AW-1:0] rd_addr;

    obj_row_drawer i_obj_row_drawer (
        .clk      (clk),
        .rst_n    (rst_n),
        .draw     (draw),
        .draw_req (draw_req),
        .busy     (busy),
        .we       (we),
        .wr       (wr)
    );

    obj_scan_reader i_obj_scan_reader (
        .clk     (clk),
        .rst_n   (rst_n),
        .lhbl    (lhbl),
        .rd      (rd),
        .rd_addr (rd_addr)
    );

    obj_line_buffer i_obj_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .lhbl      (lhbl),
        .flip      (flip),
        .we        (we),
        .wr        (wr),
        .rd        (rd),
        .rd_addr   (rd_addr),
        .pix_valid (pix_valid),
        .pix_h     (pix_h),
        .pix       (pix)
    );

endmodule

// File: rtl/obj_params.svh
// Sprite line renderer constants
// Buffer widths, transparency, erase timing and flip mapping
`ifndef OBJ_PARAMS_SVH
`define OBJ_PARAMS_SVH

// Line buffer data and per-bank address widths
`define OBJ_DW          8
`define OBJ_AW          9

// Low colour bits compared against the transparent code
`define OBJ_ALPHAW      4
`define OBJ_ALPHA       4'hF

// Erase value is palette 0 with the transparent colour
`define OBJ_BLANK       8'h0F
`define OBJ_BLANK_DLY   2

// Flipped address is ~addr plus this offset
`define OBJ_FLIP_OFFSET 9'd256

`define OBJ_LINE_LEN    256
`define OBJ_ROW_PIX     8

`endif

// File: rtl/obj_pkg.sv
// Sprite line renderer types
// Pixel word, draw request, buffer write and drawer FSM states
package obj_pkg;

    `include "obj_params.svh"

    // One buffer entry, palette in the upper nibble
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] color;
    } obj_pix_t;

    // One sprite row as handed to the drawer
    typedef struct packed {
        logic [`OBJ_AW-1:0]          x;
        logic [3:0]                  pal;
        // Pixel 0 sits in the low nibble
        logic [4*`OBJ_ROW_PIX-1:0]   row;
    } obj_draw_t;

    // Pixel write towards the line buffer, qualified by we
    typedef struct packed {
        logic [`OBJ_AW-1:0] addr;
        obj_pix_t           pix;
    } obj_wr_t;

    // Row drawer states
    typedef enum logic {
        DRW_IDLE,
        DRW_EMIT
    } obj_drw_state_e;

endpackage

// File: rtl/obj_row_drawer.sv
// Sprite row drawer
// Latches one row request and writes its pixels, one per cycle
// busy stays high for the whole burst
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_row_drawer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 draw,
    input  obj_pkg::obj_draw_t   draw_req,
    output logic                 busy,
    output logic                 we,
    output obj_pkg::obj_wr_t     wr
);

    import obj_pkg::*;

    localparam int CW = $clog2(`OBJ_ROW_PIX);
    localparam logic [CW-1:0] LAST_PIX = CW'(`OBJ_ROW_PIX - 1);

    obj_drw_state_e state;
    logic [CW-1:0]  cnt;
    // Working copy, x steps and row shifts as pixels go out
    obj_draw_t      req_q;

    // FSM and pixel counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DRW_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DRW_IDLE: begin
                    // Requests only land here, so draws while busy are dropped
                    if (draw) begin
                        state <= DRW_EMIT;
                        cnt   <= '0;
                    end
                end
                DRW_EMIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_PIX) begin
                        state <= DRW_IDLE;
                    end
                end
                default: begin
                    state <= DRW_IDLE;
                end
            endcase
        end
    end

    // Request register
    always_ff @(posedge clk) begin
        if (state == DRW_IDLE) begin
            if (draw) begin
                req_q <= draw_req;
            end
        end else begin
            // Next pixel to the right, next nibble to the bottom
            req_q.x   <= req_q.x + 1'b1;
            req_q.row <= req_q.row >> 4;
        end
    end

    assign busy = (state == DRW_EMIT);
    assign we   = busy;

    // Current pixel always comes from the low nibble
    always_comb begin
        wr.addr      = req_q.x;
        wr.pix.pal   = req_q.pal;
        wr.pix.color = req_q.row[3:0];
    end

endmodule

// File: rtl/obj_scan_reader.sv
// Line scan reader
// Walks the read bank from h = 0 once per active line
// One read strobe per cycle, stops at line end or when lhbl drops
`timescale 1ns/1ps
`include "obj_params.svh"

module obj_scan_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lhbl,
    output logic                 rd,
    output logic [`OBJ_AW-1:0]   rd_addr
);

    localparam int AW = `OBJ_AW;
    localparam logic [AW-1:0] LAST_H = AW'(`OBJ_LINE_LEN - 1);

    logic lhbl_q;
    logic lhbl_rise;

    // Start of the active line
    assign lhbl_rise = lhbl && !lhbl_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_q  <= 1'b0;
            rd      <= 1'b0;
            rd_addr <= '0;
        end else begin
            lhbl_q <= lhbl;
            if (lhbl_rise) begin
                // First read goes out next cycle at h = 0
                rd      <= 1'b1;
                rd_addr <= '0;
            end else if (rd) begin
                if (!lhbl || rd_addr == LAST_H) begin
                    // Early blank or last pixel, park the counter
                    rd <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sprite line renderer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module obj_line_render_tb \
    -f obj_line_render.f \
    -o obj_line_render_sim

./obj_dir/obj_line_render_sim 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
echo "Result: PASS"
